// ==== hdl/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////
`define ADDR_BITS     28             // Word address width
`define DATA_BITS     32             // One word per line
`define INDEX_BITS    3              // 8 lines

//////////////////////////////////////////////////////////////////////
// Traffic pattern
//////////////////////////////////////////////////////////////////////
`define PAT_ENTRIES   16             // Entries per pass
`define PAT_TAG_BASE  25'h100        // Tag of entries 0 to 7
`define PAT_DATA_BASE 32'h0100_00FF  // Data of entry 0 in pass 0
`define PAT_DATA_STEP 32'h0011_1111  // Added per entry

// Idle cycles between a ready and the next command
`define SEQ_GAP       4

`endif

// ==== hdl/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////
	typedef logic [`ADDR_BITS-1:0]              addr_t;   // Word address
	typedef logic [`DATA_BITS-1:0]              data_t;   // Data word
	typedef logic [`ADDR_BITS-`INDEX_BITS-1:0]  tag_t;    // Upper address bits
	typedef logic [`INDEX_BITS-1:0]             index_t;  // Line select
	typedef logic [7:0]                         pass_t;   // Wraps after 255
	typedef data_t                              exp_t;    // Expected read data

	//////////////////////////////////////////////////////////////////////
	// Bus structs
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic  valid;   // Level, held until ready
		logic  rw;      // 1 = write
		addr_t addr;
		data_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  ready;   // One-cycle pulse
		data_t rdata;   // Valid with ready on reads
	} cpu_rsp_t;

	typedef struct packed {
		logic  valid;   // Level, held until mem_ready
		logic  rw;      // 1 = write
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	// Sequencer FSM
	typedef enum logic [1:0] {
		SEQ_IDLE,       // Start low
		SEQ_ISSUE,      // First cycle of a command
		SEQ_WAIT,       // Command held until ready
		SEQ_GAP         // Idle cycles after ready
	} seq_state_t;

endpackage

// ==== hdl/traffic_sequencer.sv ====
`timescale 1ns/10ps
`include "dcache_macros.svh"

module traffic_sequencer
	import dcache_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,      // Run passes while high
	output cpu_req_t cpu_req,
	input  cpu_rsp_t cpu_rsp,
	output exp_t     exp,        // Expected data of the current read
	output logic     pass_done   // Pulse after the last read of a pass
);

	localparam int ENT_BITS = $clog2(`PAT_ENTRIES);
	localparam int GAP_BITS = $clog2(`SEQ_GAP + 1);

	localparam logic [ENT_BITS-1:0] ENT_LAST = ENT_BITS'(`PAT_ENTRIES - 1);
	localparam logic [GAP_BITS-1:0] GAP_LAST = GAP_BITS'(`SEQ_GAP - 1);

	seq_state_t          state_q;
	logic [ENT_BITS-1:0] entry_q;      // Table entry k
	logic                wr_phase_q;   // Write pass, else read pass
	logic                rd_second_q;  // Second read of the entry
	logic [GAP_BITS-1:0] gap_q;        // Idle cycle count
	pass_t               pass_q;       // Pass number p

	index_t pat_index;
	tag_t   pat_tag;
	data_t  pat_data;

	//////////////////////////////////////////////////////////////////////
	// Pattern rule
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		pat_index = index_t'(entry_q);                              // k mod lines
		pat_tag   = `PAT_TAG_BASE + tag_t'(entry_q >> `INDEX_BITS);  // Base plus k div lines
		pat_data  = `PAT_DATA_BASE
		          + data_t'(entry_q) * `PAT_DATA_STEP
		          + data_t'(pass_q);                               // Changes every pass
	end

	// Fields come from the counters, so they hold while the command waits
	always_comb
	begin
		cpu_req.valid = (state_q == SEQ_ISSUE) || (state_q == SEQ_WAIT);
		cpu_req.rw    = wr_phase_q;
		cpu_req.addr  = {pat_tag, pat_index};
		cpu_req.wdata = pat_data;
		exp           = pat_data;  // Same rule as the write
	end

	//////////////////////////////////////////////////////////////////////
	// Command FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q     <= SEQ_IDLE;
			entry_q     <= '0;
			wr_phase_q  <= 1'b1;      // Each pass opens with writes
			rd_second_q <= 1'b0;
			gap_q       <= '0;
			pass_q      <= '0;
			pass_done   <= 1'b0;
		end
		else
		begin
			pass_done <= 1'b0;        // Pulse by default low
			case (state_q)
				SEQ_IDLE:
				begin
					if (start)
						state_q <= SEQ_ISSUE;  // Resume at the saved entry
				end
				SEQ_ISSUE:
				begin
					state_q <= SEQ_WAIT;       // Cache answers one cycle later at best
				end
				SEQ_WAIT:
				begin
					if (cpu_rsp.ready)
					begin
						state_q <= SEQ_GAP;
						gap_q   <= '0;
						if (wr_phase_q)
						begin
							entry_q <= entry_q + 1'b1;  // Wraps to 0 after last
							if (entry_q == ENT_LAST)
								wr_phase_q <= 1'b0;     // Switch to reads
						end
						else if (!rd_second_q)
							rd_second_q <= 1'b1;        // Read the entry again
						else
						begin
							rd_second_q <= 1'b0;
							entry_q     <= entry_q + 1'b1;
							if (entry_q == ENT_LAST)
							begin
								wr_phase_q <= 1'b1;     // Next pass
								pass_q     <= pass_q + 1'b1;
								pass_done  <= 1'b1;
							end
						end
					end
				end
				SEQ_GAP:
				begin
					if (gap_q == GAP_LAST)
						state_q <= start ? SEQ_ISSUE : SEQ_IDLE;
					else
						gap_q <= gap_q + 1'b1;
				end
				default:
				begin
					state_q <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hdl/dcache_core.sv ====
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_core
	import dcache_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output mem_req_t mem_req,    // External memory bus
	input  data_t    mem_rdata,
	input  logic     mem_ready   // One pulse per memory command
);

	localparam int LINES = 1 << `INDEX_BITS;

	// Controller states
	typedef enum logic [1:0] {
		C_IDLE,   // Waiting for a CPU command
		C_MEM,    // Miss or write through on the memory bus
		C_RESP    // Ready pulse to the CPU
	} cache_state_t;

	cache_state_t     state_q;
	cpu_req_t         req_q;           // Accepted command
	data_t            rdata_q;         // Read data to the CPU
	logic [LINES-1:0] valid_q;         // Line valid bits
	tag_t             tag_arr [LINES];
	data_t            data_arr [LINES];

	index_t in_index;
	tag_t   in_tag;
	logic   in_hit;                    // Lookup of the incoming command
	index_t req_index;
	tag_t   req_tag;
	logic   req_hit;                   // Lookup of the held command

	//////////////////////////////////////////////////////////////////////
	// Tag lookup
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		in_index  = cpu_req.addr[`INDEX_BITS-1:0];
		in_tag    = cpu_req.addr[`ADDR_BITS-1:`INDEX_BITS];
		in_hit    = valid_q[in_index] && (tag_arr[in_index] == in_tag);

		req_index = req_q.addr[`INDEX_BITS-1:0];
		req_tag   = req_q.addr[`ADDR_BITS-1:`INDEX_BITS];
		req_hit   = valid_q[req_index] && (tag_arr[req_index] == req_tag);
	end

	//////////////////////////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= C_IDLE;
			valid_q <= '0;                // Cache starts empty
		end
		else
		begin
			case (state_q)
				C_IDLE:
				begin
					if (cpu_req.valid)
					begin
						if (!cpu_req.rw && in_hit)
							state_q <= C_RESP;   // Read hit
						else
							state_q <= C_MEM;    // Read miss or any write
					end
				end
				C_MEM:
				begin
					if (mem_ready)
					begin
						state_q <= C_RESP;
						if (!req_q.rw)
							valid_q[req_index] <= 1'b1;  // Line filled
					end
				end
				C_RESP:
				begin
					state_q <= C_IDLE;           // Valid drops while here
				end
				default:
				begin
					state_q <= C_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (state_q == C_IDLE && cpu_req.valid)
		begin
			req_q   <= cpu_req;                  // Held for the memory bus
			rdata_q <= data_arr[in_index];       // Used on a hit
		end
		if (state_q == C_MEM && mem_ready)
		begin
			if (!req_q.rw)
			begin
				tag_arr[req_index]  <= req_tag;  // Fill on read miss
				data_arr[req_index] <= mem_rdata;
				rdata_q             <= mem_rdata;
			end
			else if (req_hit)
				data_arr[req_index] <= req_q.wdata;  // No allocate on write miss
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		mem_req.valid = (state_q == C_MEM);
		mem_req.rw    = req_q.rw;
		mem_req.addr  = req_q.addr;
		mem_req.wdata = req_q.wdata;
		cpu_rsp.ready = (state_q == C_RESP);       // Exactly one cycle
		cpu_rsp.rdata = rdata_q;
	end

endmodule

// ==== hdl/response_checker.sv ====
`timescale 1ns/10ps

module response_checker
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  cpu_req_t    cpu_req,
	input  cpu_rsp_t    cpu_rsp,
	input  exp_t        exp,            // Held while the read is outstanding
	output logic        error,          // Level of the last read result
	output logic [15:0] mismatch_count  // Saturating
);

	logic rd_q;      // Outstanding command is a read
	logic rd_rsp;    // Read response this cycle
	logic mismatch;  // Read data differs from expected

	always_comb
	begin
		rd_rsp   = cpu_rsp.ready && rd_q;
		mismatch = (cpu_rsp.rdata != exp);
	end

	//////////////////////////////////////////////////////////////////////
	// Result tracking
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_q           <= 1'b0;
			error          <= 1'b0;
			mismatch_count <= '0;
		end
		else
		begin
			if (cpu_req.valid)
				rd_q <= !cpu_req.rw;    // Stable until ready
			if (rd_rsp)
			begin
				error <= mismatch;      // Cleared by a good read
				if (mismatch && mismatch_count != '1)
					mismatch_count <= mismatch_count + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/dcache_exerciser.sv ====
`timescale 1ns/10ps

module dcache_exerciser
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,          // Run passes while high
	output mem_req_t    mem_req,        // Cache to memory
	input  data_t       mem_rdata,
	input  logic        mem_ready,      // Memory done pulse
	output logic        pass_done,
	output logic        error,
	output logic [15:0] mismatch_count
);

	cpu_req_t cpu_req;  // Sequencer to cache
	cpu_rsp_t cpu_rsp;  // Cache to sequencer and checker
	exp_t     exp;      // Sequencer to checker

	//////////////////////////////////////////////////////////////////////
	// Decode, execute, result
	//////////////////////////////////////////////////////////////////////
	traffic_sequencer u_sequencer (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.cpu_req   (cpu_req),
		.cpu_rsp   (cpu_rsp),
		.exp       (exp),
		.pass_done (pass_done)
	);

	dcache_core u_cache (
		.clk       (clk),
		.rst       (rst),
		.cpu_req   (cpu_req),
		.cpu_rsp   (cpu_rsp),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	response_checker u_checker (
		.clk            (clk),
		.rst            (rst),
		.cpu_req        (cpu_req),
		.cpu_rsp        (cpu_rsp),
		.exp            (exp),
		.error          (error),
		.mismatch_count (mismatch_count)
	);

endmodule

// ==== sim/tb_mem_responder.sv ====
`timescale 1ns/10ps

module tb_mem_responder
	import dcache_pkg::*;
(
	input  logic     clk,
	input  mem_req_t mem_req,       // From the cache
	output data_t    mem_rdata,
	output logic     mem_ready,     // One pulse per command
	input  logic     corrupt_next   // Pulse arms one bad read
);

	data_t       mem [addr_t];        // Sparse word store
	logic        busy = 1'b0;         // Command being served
	int unsigned delay = 0;           // Cycles left
	int unsigned arm_count = 0;       // Corruptions requested
	int unsigned used_count = 0;      // Corruptions applied
	logic        ready_q = 1'b0;
	data_t       rdata_q = '0;
	data_t       word;

	assign mem_ready = ready_q;
	assign mem_rdata = rdata_q;

	always @(posedge clk)
	begin
		if (corrupt_next)
			arm_count <= arm_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Answer on the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		ready_q = 1'b0;
		if (mem_req.valid && !busy)
		begin
			busy  = 1'b1;
			delay = $urandom % 6 + 1;       // 1 to 6 cycles
		end
		if (busy)
		begin
			delay = delay - 1;
			if (delay == 0)
			begin
				busy    = 1'b0;
				ready_q = 1'b1;
				if (mem_req.rw)
					mem[mem_req.addr] = mem_req.wdata;
				else
				begin
					// Unwritten words return a fill tied to the address
					word = mem.exists(mem_req.addr) ? mem[mem_req.addr] : {4'hD, mem_req.addr};
					if (arm_count != used_count)
					begin
						word       = word ^ 32'h1;  // Flip bit 0 once
						used_count = arm_count;
					end
					rdata_q = word;
				end
			end
		end
	end

endmodule

// ==== sim/tb_dcache_exerciser.sv ====
`timescale 1ns/10ps
`include "dcache_macros.svh"

module tb_dcache_exerciser
	import dcache_pkg::*;
();

	localparam int TIMEOUT = 2000;  // Cycles allowed per wait
	localparam int W_PASS  = 0;     // Wait for pass_done
	localparam int W_LOG   = 1;     // Wait for a memory command count
	localparam int W_ERR   = 2;     // Wait for an error level

	logic        clk = 1'b0;
	logic        rst;
	logic        start;
	logic        corrupt_next;
	mem_req_t    mem_req;
	data_t       mem_rdata;
	logic        mem_ready;
	logic        pass_done;
	logic        error;
	logic [15:0] mismatch_count;

	mem_req_t txn;                  // Completed memory command
	mem_req_t txn_log [$];          // Reads carry the returned word
	int       pass_count = 0;
	int       error_cycles = 0;
	int       err_count = 0;
	int       timeout_count = 0;

	dcache_exerciser UUT (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.mem_req        (mem_req),
		.mem_rdata      (mem_rdata),
		.mem_ready      (mem_ready),
		.pass_done      (pass_done),
		.error          (error),
		.mismatch_count (mismatch_count)
	);

	tb_mem_responder u_mem (
		.clk          (clk),
		.mem_req      (mem_req),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.corrupt_next (corrupt_next)
	);

	always #4 clk = ~clk;           // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// Bus monitor
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (mem_req.valid && mem_ready)
			begin
				txn = mem_req;
				if (!mem_req.rw)
					txn.wdata = mem_rdata;
				txn_log.push_back(txn);
			end
			if (pass_done)
				pass_count++;
			if (error)
				error_cycles++;
		end
	end

	// Entry k sits at index k mod 8 under tag base plus k div 8
	function automatic addr_t entry_addr(input int k);
		logic [24:0] tag;
		tag = `PAT_TAG_BASE + 25'(k / 8);
		return {tag, 3'(k % 8)};
	endfunction

	function automatic data_t entry_data(input int k, input int p);
		return `PAT_DATA_BASE + 32'(k) * `PAT_DATA_STEP + 32'(p);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			err_count++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	function automatic logic cond_met(input int sel, input int value);
		case (sel)
			W_PASS:  return pass_done === 1'b1;
			W_LOG:   return txn_log.size() >= value;
			default: return error === 1'(value);
		endcase
	endfunction

	// Polls on the falling edge, gives up after TIMEOUT cycles
	task automatic wait_until(input string what, input int sel, input int value);
		int n;
		n = 0;
		while (!cond_met(sel, value) && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!cond_met(sel, value))
		begin
			timeout_count++;
			$display("Timeout: no %s within %0d clock cycles", what, TIMEOUT);
		end
	endtask

	task automatic expect_quiet(input string when_txt);
		check_value({"mem_req.valid ", when_txt}, 32'(mem_req.valid), 32'd0);
		check_value({"pass_done ", when_txt}, 32'(pass_done), 32'd0);
		check_value({"error ", when_txt}, 32'(error), 32'd0);
		check_value({"mismatch_count ", when_txt}, 32'(mismatch_count), 32'd0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic reset_and_idle();
		repeat (8)
		begin
			@(negedge clk);
			expect_quiet("in reset");
		end
		rst = 1'b0;
		repeat (20)
		begin
			@(negedge clk);
			expect_quiet("with start low");
		end
	endtask

	// Writes then paired reads; the second read must stay off the bus
	task automatic run_clean_pass(input int p);
		int       base;
		int       passes;
		int       err_cyc;
		int       k;
		mem_req_t t;
		base    = txn_log.size();
		passes  = pass_count;
		err_cyc = error_cycles;
		start   = 1'b1;
		wait_until("pass_done", W_PASS, 0);
		@(negedge clk);                 // Monitor counts the pulse
		check_value("pass_done pulses", 32'(pass_count - passes), 32'd1);
		check_value("memory commands", 32'(txn_log.size() - base), 32'd32);
		check_value("cycles with error", 32'(error_cycles - err_cyc), 32'd0);
		check_value("mismatch_count", 32'(mismatch_count), 32'd0);
		for (int i = 0; i < 32 && base + i < txn_log.size(); i++)
		begin
			t = txn_log[base + i];
			k = i % 16;
			check_value($sformatf("rw of command %0d", i), 32'(t.rw), 32'(i < 16));
			check_value($sformatf("addr of command %0d", i), 32'(t.addr), 32'(entry_addr(k)));
			check_value($sformatf("data of command %0d", i), t.wdata, entry_data(k, p));
		end
	endtask

	task automatic inject_corruption();
		int base;
		base = txn_log.size();
		wait_until("end of the write phase", W_LOG, base + 16);
		corrupt_next = 1'b1;            // Hits the first read of entry 0
		@(negedge clk);
		corrupt_next = 1'b0;
		wait_until("rise of error", W_ERR, 1);
		check_value("mismatch_count after the miss", 32'(mismatch_count), 32'd1);
		wait_until("clear of error", W_ERR, 0);
		check_value("mismatch_count after recovery", 32'(mismatch_count), 32'd2);
		wait_until("pass_done", W_PASS, 0);
		@(negedge clk);
	endtask

	task automatic stop_mid_pass();
		int base;
		int cut;
		int passes;
		base = txn_log.size();
		wait_until("traffic before the stop", W_LOG, base + 5);
		start  = 1'b0;
		cut    = txn_log.size();
		passes = pass_count;
		repeat (200) @(negedge clk);    // Far longer than one command
		check_value("at most one command after stop", 32'(txn_log.size() - cut <= 1), 32'd1);
		check_value("pass_done after stop", 32'(pass_count - passes), 32'd0);
		check_value("mem_req.valid after stop", 32'(mem_req.valid), 32'd0);
	endtask

	initial
	begin
		rst          = 1'b1;
		start        = 1'b0;
		corrupt_next = 1'b0;
		void'($urandom(32'h69ff_8731));
		reset_and_idle();
		run_clean_pass(0);
		run_clean_pass(1);              // New data over cached lines
		inject_corruption();
		stop_mid_pass();
		$display("Errors: %0d, timeouts: %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== dcache_exerciser.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/traffic_sequencer.sv
hdl/dcache_core.sv
hdl/response_checker.sv
hdl/dcache_exerciser.sv
sim/tb_mem_responder.sv
sim/tb_dcache_exerciser.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --timescale 1ns/10ps --top-module tb_dcache_exerciser \
	-f dcache_exerciser.f -o tb_dcache_exerciser > build.log 2>&1 \
	&& ./obj_dir/tb_dcache_exerciser > sim.log 2>&1 \
	|| { echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
	&& echo "Result: PASS" \
	|| { echo "Result: FAIL, see sim.log"; exit 1; }
